/* src/cpu_pkg.sv */
package cpu_pkg;

	typedef logic [15:0] word_t;
	typedef logic [23:0] instr_t;
	typedef logic [2:0]  type_t;
	typedef logic [4:0]  alu_op_t;
	typedef logic [2:0]  cond_t;
	typedef logic [2:0]  flag_sel_t;
	typedef logic [1:0]  wb_sel_t;
	typedef logic [7:0]  pc_t;      // program and data address
	typedef logic [7:0]  imm_t;
	typedef logic [3:0]  reg_idx_t;

	// gray sequence, one bit flips per step
	typedef enum logic [1:0] {
		if_s = 2'b00,
		id_s = 2'b01,
		ex_s = 2'b11,
		wb_s = 2'b10
	} state_t;

	localparam int NUM_REGS  = 16;
	localparam int MEM_WORDS = 256;   // both memories

	localparam int TYPE_HI = 23;
	localparam int TYPE_LO = 21;
	localparam int OP_HI   = 20;
	localparam int OP_LO   = 16;
	localparam int RD_HI   = 15;
	localparam int RD_LO   = 12;
	localparam int RA_HI   = 11;
	localparam int RA_LO   = 8;
	localparam int RB_HI   = 7;
	localparam int RB_LO   = 4;
	localparam int IMM_HI  = 7;    // overlaps rb
	localparam int IMM_LO  = 0;

	localparam type_t TYPE_BRANCH  = 3'b000;
	localparam type_t TYPE_ALU_REG = 3'b001;
	localparam type_t TYPE_ALU_IMM = 3'b010;
	localparam type_t TYPE_MEM     = 3'b100;
	localparam type_t TYPE_JUMP    = 3'b110;

	localparam alu_op_t ALU_AND    = 5'b00000;
	localparam alu_op_t ALU_OR     = 5'b00001;
	localparam alu_op_t ALU_XOR    = 5'b00010;
	localparam alu_op_t ALU_NOT    = 5'b00011;
	localparam alu_op_t ALU_NAND   = 5'b00100;
	localparam alu_op_t ALU_SHL    = 5'b01000;
	localparam alu_op_t ALU_SHR    = 5'b01001;
	localparam alu_op_t ALU_SAR    = 5'b01010;
	localparam alu_op_t ALU_ROL    = 5'b01011;
	localparam alu_op_t ALU_MOV    = 5'b10000;
	localparam alu_op_t ALU_ADD    = 5'b10001;
	localparam alu_op_t ALU_SUB    = 5'b10010;
	localparam alu_op_t ALU_PASS_B = 5'b10011;
	localparam alu_op_t ALU_NOP    = 5'b11111;

	localparam cond_t COND_NEVER       = 3'b000;
	localparam cond_t COND_ZERO        = 3'b001;
	localparam cond_t COND_NEGATIVE    = 3'b010;
	localparam cond_t COND_ALWAYS_LINK = 3'b011;
	localparam cond_t COND_CARRY       = 3'b100;
	localparam cond_t COND_NOT_ZERO    = 3'b101;
	localparam cond_t COND_OVERFLOW    = 3'b110;
	localparam cond_t COND_NONE        = 3'b111;

	localparam flag_sel_t FLAG_NONE     = 3'b000;
	localparam flag_sel_t FLAG_ZN       = 3'b001;
	localparam flag_sel_t FLAG_ZNCO     = 3'b010;
	localparam flag_sel_t FLAG_ZNC      = 3'b011;
	localparam flag_sel_t FLAG_ZN_LOGIC = 3'b100;  // carry and overflow cleared

	localparam wb_sel_t WB_LINK = 2'b00;
	localparam wb_sel_t WB_MEM  = 2'b01;
	localparam wb_sel_t WB_ALU  = 2'b10;

endpackage

/* src/unit_control.sv */
`timescale 1ns/1ns

module unit_control
	import cpu_pkg::*;
(
	input  logic      CLK,
	input  logic      rst,
	input  type_t     instr_type,
	input  alu_op_t   op,
	input  logic      take_branch,
	output alu_op_t   alu_op,
	output cond_t     test_code,
	output logic      sign_ext,
	output logic      pc_we,
	output logic      branch_sel,
	output logic      dm_we,
	output logic      rb_we,
	output flag_sel_t flag_we_sel,
	output wb_sel_t   wb_sel,
	output logic      imm_sel
);

	state_t    state, next_state;
	cond_t     br_cond;
	alu_op_t   dec_alu_op;
	cond_t     dec_test;
	logic      dec_sign_ext;
	logic      dec_imm_sel;
	logic      dec_dm_we;
	logic      dec_rb_we;
	flag_sel_t dec_flag_sel;
	wb_sel_t   dec_wb_sel;

	assign br_cond = {op[2], op[3], op[4]};  // bit-reversed test field

	always_comb begin
		case (state)
			if_s: next_state = id_s;
			id_s: next_state = ex_s;
			ex_s: next_state = wb_s;
			default: next_state = if_s;
		endcase
	end

	// the instruction register holds the current word from EX until the next ID
	always_comb begin
		dec_alu_op   = ALU_NOP;
		dec_test     = COND_NONE;
		dec_sign_ext = 1'b0;
		dec_imm_sel  = 1'b0;
		dec_dm_we    = 1'b0;
		dec_rb_we    = 1'b0;
		dec_flag_sel = FLAG_NONE;
		dec_wb_sel   = WB_ALU;
		case (instr_type)
			TYPE_ALU_REG, TYPE_ALU_IMM: begin
				dec_alu_op = op;
				dec_rb_we  = (op != ALU_NOP);
				if (op == ALU_NOP)
					dec_flag_sel = FLAG_NONE;
				else if (op == ALU_MOV)
					dec_flag_sel = FLAG_ZN;
				else if (op[4:3] == 2'b01)
					dec_flag_sel = FLAG_ZNC;      // shifts
				else if (op[4:3] == 2'b00)
					dec_flag_sel = FLAG_ZN_LOGIC;
				else
					dec_flag_sel = FLAG_ZNCO;     // add, sub, pass b
				if (instr_type == TYPE_ALU_IMM) begin
					dec_imm_sel  = 1'b1;
					dec_sign_ext = (op[4:3] != 2'b00);  // logic ops zero-extend
				end
			end
			TYPE_MEM: begin
				dec_alu_op = ALU_MOV;  // address comes from ra
				dec_dm_we  = op[4];    // store
				dec_rb_we  = ~op[4];   // load
				dec_wb_sel = WB_MEM;
			end
			TYPE_BRANCH: begin
				dec_alu_op  = ALU_PASS_B;
				dec_test    = br_cond;
				dec_imm_sel = 1'b1;     // absolute immediate target
			end
			TYPE_JUMP: begin
				dec_alu_op = ALU_PASS_B;  // target from rb
				dec_test   = br_cond;
				dec_rb_we  = (br_cond == COND_ALWAYS_LINK);
				dec_wb_sel = WB_LINK;
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			state       <= if_s;
			pc_we       <= 1'b0;
			branch_sel  <= 1'b0;
			dm_we       <= 1'b0;
			rb_we       <= 1'b0;
			flag_we_sel <= FLAG_NONE;
			alu_op      <= ALU_NOP;
			test_code   <= COND_NONE;
			sign_ext    <= 1'b0;
			imm_sel     <= 1'b0;
			wb_sel      <= WB_ALU;
		end else begin
			state       <= next_state;
			pc_we       <= (state == if_s);
			branch_sel  <= (state == if_s) && take_branch;  // previous instruction's test
			dm_we       <= (state == ex_s) && dec_dm_we;
			rb_we       <= (state == wb_s) && dec_rb_we;
			flag_we_sel <= (state == wb_s) ? dec_flag_sel : FLAG_NONE;
			// execute controls stay put until the next EX so the target survives into ID
			if (state == ex_s) begin
				alu_op    <= dec_alu_op;
				test_code <= dec_test;
				sign_ext  <= dec_sign_ext;
				imm_sel   <= dec_imm_sel;
			end
			if (state == wb_s)
				wb_sel <= dec_wb_sel;
		end
	end

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit
	import cpu_pkg::*;
(
	input  logic   CLK,
	input  logic   rst,
	input  logic   pc_we,
	input  logic   branch_sel,
	input  pc_t    target,
	input  logic   prog_we,
	input  pc_t    prog_addr,
	input  instr_t prog_data,
	output instr_t instr,
	output pc_t    pc
);

	instr_t imem [MEM_WORDS];
	pc_t    fetch_addr;

	// a taken branch fetches straight from the target, no delay slot
	assign fetch_addr = branch_sel ? target : pc;

	always_ff @(posedge CLK) begin
		if (rst && prog_we)
			imem[prog_addr] <= prog_data;  // program load only while in reset
	end

	always_ff @(posedge CLK) begin
		if (rst)
			pc <= '0;
		else if (pc_we)
			pc <= fetch_addr + 8'd1;   // pc always points past the fetched word
	end

	always_ff @(posedge CLK) begin
		if (pc_we)
			instr <= imem[fetch_addr];
	end

endmodule

/* src/reg_bank.sv */
`timescale 1ns/1ns

module reg_bank
	import cpu_pkg::*;
(
	input  logic     CLK,
	input  logic     rst,
	input  logic     we,
	input  reg_idx_t wa,
	input  reg_idx_t ra_idx,
	input  reg_idx_t rb_idx,
	input  wb_sel_t  wb_sel,
	input  word_t    link_data,
	input  word_t    mem_data,
	input  word_t    alu_data,
	output word_t    rdata_a,
	output word_t    rdata_b
);

	word_t regs [NUM_REGS];
	word_t wdata;

	always_comb begin
		case (wb_sel)
			WB_LINK: wdata = link_data;
			WB_MEM:  wdata = mem_data;
			default: wdata = alu_data;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[wa] <= wdata;
		end
	end

	assign rdata_a = regs[ra_idx];
	assign rdata_b = regs[rb_idx];

endmodule

/* src/alu.sv */
`timescale 1ns/1ns

module alu
	import cpu_pkg::*;
(
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   reg_b,
	input  imm_t    imm,
	input  logic    imm_sel,
	input  logic    sign_ext,
	output word_t   result,
	output logic    zero,
	output logic    neg,
	output logic    carry,
	output logic    ovf
);

	word_t      operand_b;
	word_t      imm_ext;
	logic [3:0] shamt;

	assign imm_ext   = sign_ext ? {{8{imm[7]}}, imm} : {8'h00, imm};
	assign operand_b = imm_sel ? imm_ext : reg_b;
	assign shamt     = operand_b[3:0];

	always_comb begin
		result = '0;
		carry  = 1'b0;
		ovf    = 1'b0;
		case (op)
			ALU_AND:  result = a & operand_b;
			ALU_OR:   result = a | operand_b;
			ALU_XOR:  result = a ^ operand_b;
			ALU_NOT:  result = ~a;
			ALU_NAND: result = ~(a & operand_b);
			ALU_SHL:  {carry, result} = {1'b0, a} << shamt;  // carry is last bit out
			ALU_SHR:  {result, carry} = {a, 1'b0} >> shamt;
			ALU_SAR:  {result, carry} = $signed({a, 1'b0}) >>> shamt;
			ALU_ROL:  result = (a << shamt) | (a >> (5'd16 - shamt));
			ALU_MOV:  result = a;
			ALU_ADD: begin
				{carry, result} = {1'b0, a} + {1'b0, operand_b};
				ovf = (a[15] == operand_b[15]) && (result[15] != a[15]);
			end
			ALU_SUB: begin
				{carry, result} = {1'b0, a} - {1'b0, operand_b};  // carry set on borrow
				ovf = (a[15] != operand_b[15]) && (result[15] != a[15]);
			end
			ALU_PASS_B: result = operand_b;  // branch and jump target
			default:    result = '0;
		endcase
	end

	assign zero = (result == '0);
	assign neg  = result[15];

endmodule

/* src/flag_unit.sv */
`timescale 1ns/1ns

module flag_unit
	import cpu_pkg::*;
(
	input  logic      CLK,
	input  logic      rst,
	input  flag_sel_t flag_we_sel,
	input  logic      zero,
	input  logic      neg,
	input  logic      carry,
	input  logic      ovf,
	input  cond_t     test_code,
	output logic      take_branch,
	output logic      link
);

	logic z_q, n_q, c_q, o_q;

	always_ff @(posedge CLK) begin
		if (rst) begin
			z_q <= 1'b0;
			n_q <= 1'b0;
			c_q <= 1'b0;
			o_q <= 1'b0;
		end else begin
			case (flag_we_sel)
				FLAG_ZN: begin
					z_q <= zero;
					n_q <= neg;
				end
				FLAG_ZNCO: begin
					z_q <= zero;
					n_q <= neg;
					c_q <= carry;
					o_q <= ovf;
				end
				FLAG_ZNC: begin
					z_q <= zero;
					n_q <= neg;
					c_q <= carry;
				end
				FLAG_ZN_LOGIC: begin
					z_q <= zero;
					n_q <= neg;
					c_q <= 1'b0;
					o_q <= 1'b0;
				end
				FLAG_NONE: ;
				default: ;
			endcase
		end
	end

	always_comb begin
		case (test_code)
			COND_ZERO:        take_branch = z_q;
			COND_NEGATIVE:    take_branch = n_q;
			COND_ALWAYS_LINK: take_branch = 1'b1;
			COND_CARRY:       take_branch = c_q;
			COND_NOT_ZERO:    take_branch = ~z_q;
			COND_OVERFLOW:    take_branch = o_q;
			COND_NEVER, COND_NONE: take_branch = 1'b0;
			default:          take_branch = 1'b0;
		endcase
	end

	assign link = (test_code == COND_ALWAYS_LINK);  // current instruction's code

endmodule

/* src/data_mem.sv */
`timescale 1ns/1ns

module data_mem
	import cpu_pkg::*;
(
	input  logic  CLK,
	input  logic  we,
	input  pc_t   addr,
	input  word_t wdata,
	output word_t rdata
);

	word_t mem [MEM_WORDS];

	always_ff @(posedge CLK) begin
		if (we)
			mem[addr] <= wdata;
	end

	assign rdata = mem[addr];  // read through, used by loads

endmodule

/* src/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top
	import cpu_pkg::*;
(
	input  logic   CLK,
	input  logic   rst,
	input  logic   prog_we,
	input  pc_t    prog_addr,
	input  instr_t prog_data,
	output pc_t    pc,
	output logic   dm_we,
	output pc_t    dm_addr,
	output word_t  dm_wdata
);

	instr_t    instr;
	type_t     instr_type;
	alu_op_t   instr_op;
	reg_idx_t  rd, ra, rb;
	imm_t      imm;
	alu_op_t   alu_op;
	cond_t     test_code;
	flag_sel_t flag_we_sel;
	wb_sel_t   wb_sel;
	logic      sign_ext, imm_sel, pc_we, branch_sel, rb_we, rb_write;
	logic      take_branch, link;
	logic      zero, neg, carry, ovf;
	word_t     rdata_a, rdata_b, alu_result, mem_rdata;
	pc_t       target;

	assign instr_type = instr[TYPE_HI:TYPE_LO];
	assign instr_op   = instr[OP_HI:OP_LO];
	assign rd         = instr[RD_HI:RD_LO];
	assign ra         = instr[RA_HI:RA_LO];
	assign rb         = instr[RB_HI:RB_LO];
	assign imm        = instr[IMM_HI:IMM_LO];

	assign target   = alu_result[7:0];
	assign dm_addr  = alu_result[7:0];  // address from ra via move
	assign dm_wdata = rdata_b;
	assign rb_write = rb_we && (link || (wb_sel != WB_LINK));  // link only on always_link

	unit_control u_ctrl (
		.CLK(CLK), .rst(rst), .instr_type(instr_type), .op(instr_op),
		.take_branch(take_branch), .alu_op(alu_op), .test_code(test_code),
		.sign_ext(sign_ext), .pc_we(pc_we), .branch_sel(branch_sel), .dm_we(dm_we),
		.rb_we(rb_we), .flag_we_sel(flag_we_sel), .wb_sel(wb_sel), .imm_sel(imm_sel)
	);

	fetch_unit u_fetch (
		.CLK(CLK), .rst(rst), .pc_we(pc_we), .branch_sel(branch_sel), .target(target),
		.prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
		.instr(instr), .pc(pc)
	);

	reg_bank u_regs (
		.CLK(CLK), .rst(rst), .we(rb_write), .wa(rd), .ra_idx(ra), .rb_idx(rb),
		.wb_sel(wb_sel), .link_data({8'h00, pc}), .mem_data(mem_rdata),
		.alu_data(alu_result), .rdata_a(rdata_a), .rdata_b(rdata_b)
	);

	alu u_alu (
		.op(alu_op), .a(rdata_a), .reg_b(rdata_b), .imm(imm), .imm_sel(imm_sel),
		.sign_ext(sign_ext), .result(alu_result), .zero(zero), .neg(neg),
		.carry(carry), .ovf(ovf)
	);

	flag_unit u_flags (
		.CLK(CLK), .rst(rst), .flag_we_sel(flag_we_sel), .zero(zero), .neg(neg),
		.carry(carry), .ovf(ovf), .test_code(test_code), .take_branch(take_branch),
		.link(link)
	);

	data_mem u_dmem (
		.CLK(CLK), .we(dm_we), .addr(dm_addr), .wdata(dm_wdata), .rdata(mem_rdata)
	);

endmodule

/* dv/cpu_asserts.sv */
`timescale 1ns/1ns

module cpu_asserts
	import cpu_pkg::*;
(
	input logic      CLK,
	input logic      rst,
	input state_t    state,
	input logic      pc_we,
	input logic      dm_we,
	input logic      rb_we,
	input flag_sel_t flag_we_sel
);

	int fails = 0;

	// gray order if, id, ex, wb
	a_if_id: assert property (@(posedge CLK) !rst && state == if_s |=> state == id_s)
		else begin
			$error("state left IF for something other than ID");
			fails++;
		end
	a_id_ex: assert property (@(posedge CLK) !rst && state == id_s |=> state == ex_s)
		else begin
			$error("state left ID for something other than EX");
			fails++;
		end
	a_ex_wb: assert property (@(posedge CLK) !rst && state == ex_s |=> state == wb_s)
		else begin
			$error("state left EX for something other than WB");
			fails++;
		end
	a_wb_if: assert property (@(posedge CLK) !rst && state == wb_s |=> state == if_s)
		else begin
			$error("state left WB for something other than IF");
			fails++;
		end

	a_mem_reg: assert property (@(posedge CLK) disable iff (rst) !(dm_we && rb_we))
		else begin
			$error("store and register write in the same cycle");
			fails++;
		end

	// each strobe on its own, rb_we is followed directly by the next pc_we
	a_pc_pulse: assert property (@(posedge CLK) disable iff (rst) pc_we |=> !pc_we)
		else begin
			$error("pc_we held for more than one cycle");
			fails++;
		end
	a_dm_pulse: assert property (@(posedge CLK) disable iff (rst) dm_we |=> !dm_we)
		else begin
			$error("dm_we held for more than one cycle");
			fails++;
		end
	a_rb_pulse: assert property (@(posedge CLK) disable iff (rst) rb_we |=> !rb_we)
		else begin
			$error("rb_we held for more than one cycle");
			fails++;
		end

	a_reset: assert property (@(posedge CLK)
		rst |=> (!pc_we && !dm_we && !rb_we && flag_we_sel == FLAG_NONE))
		else begin
			$error("strobe active during reset");
			fails++;
		end

endmodule

bind unit_control cpu_asserts i_asserts (
	.CLK(CLK), .rst(rst), .state(state), .pc_we(pc_we), .dm_we(dm_we),
	.rb_we(rb_we), .flag_we_sel(flag_we_sel)
);

/* dv/tb_cpu.sv */
`timescale 1ns/1ns

module tb_cpu
	import cpu_pkg::*;
;

	localparam int K_REG = 0;
	localparam int K_IMM = 1;
	localparam int K_MEM = 2;
	localparam int K_BR  = 3;
	localparam int K_NOP = 4;
	localparam int K_MOV = 5;
	localparam int K_JMP = 6;
	localparam int NUM_CASES = 24;
	localparam int STORE_TIMEOUT = 200;

	typedef struct packed {
		logic [2:0] kind;
		alu_op_t    op;
		cond_t      cond;
		logic       fixed;    // use a and b as given
		word_t      a;
		word_t      b;
	} test_entry_t;

	logic   CLK;
	logic   rst;
	logic   prog_we;
	pc_t    prog_addr;
	instr_t prog_data;
	pc_t    pc;
	logic   dm_we;
	pc_t    dm_addr;
	word_t  dm_wdata;

	test_entry_t cases [NUM_CASES];
	instr_t      prog[$];
	pc_t         exp_addr[$];
	word_t       exp_data[$];
	pc_t         exp_pc;
	logic [31:0] rng;
	int          errors;
	int          cases_ok;
	int          assert_fails;

	cpu_top i_dut (
		.CLK(CLK), .rst(rst), .prog_we(prog_we), .prog_addr(prog_addr),
		.prog_data(prog_data), .pc(pc), .dm_we(dm_we), .dm_addr(dm_addr),
		.dm_wdata(dm_wdata)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// branch test code sits bit-reversed in op[4:2]
	function automatic alu_op_t cond_op(input cond_t c);
		return {c[0], c[1], c[2], 2'b00};
	endfunction

	function automatic instr_t enc_reg(input alu_op_t op, input int rd, input int ra, input int rb);
		return {TYPE_ALU_REG, op, rd[3:0], ra[3:0], rb[3:0], 4'h0};
	endfunction

	function automatic instr_t enc_imm(input alu_op_t op, input int rd, input int ra, input imm_t v);
		return {TYPE_ALU_IMM, op, rd[3:0], ra[3:0], v};
	endfunction

	function automatic instr_t enc_store(input int ra, input int rb);
		return {TYPE_MEM, 5'b10000, 4'h0, ra[3:0], rb[3:0], 4'h0};
	endfunction

	function automatic instr_t enc_load(input int rd, input int ra);
		return {TYPE_MEM, 5'b00000, rd[3:0], ra[3:0], 8'h00};
	endfunction

	function automatic instr_t enc_branch(input cond_t c, input int target);
		return {TYPE_BRANCH, cond_op(c), 8'h00, target[7:0]};
	endfunction

	function automatic instr_t enc_jump(input int rd, input int rb);
		return {TYPE_JUMP, cond_op(COND_ALWAYS_LINK), rd[3:0], 4'h0, rb[3:0], 4'h0};
	endfunction

	// model of one ALU instruction, flags updated by its class
	function automatic word_t ref_alu(input alu_op_t op, input word_t a, input word_t b,
			inout logic z, inout logic n, inout logic c, inout logic o);
		word_t       r;
		logic        cy;
		logic        ov;
		logic [16:0] wide;
		int          s;
		s = b[3:0];
		r = '0;
		cy = 1'b0;
		ov = 1'b0;
		case (op)
			ALU_AND:  r = a & b;
			ALU_OR:   r = a | b;
			ALU_XOR:  r = a ^ b;
			ALU_NOT:  r = ~a;
			ALU_NAND: r = ~(a & b);
			ALU_SHL: begin
				r = a << s;
				cy = (s == 0) ? 1'b0 : a[16 - s];
			end
			ALU_SHR: begin
				r = a >> s;
				cy = (s == 0) ? 1'b0 : a[s - 1];
			end
			ALU_SAR: begin
				r = $signed(a) >>> s;
				cy = (s == 0) ? 1'b0 : a[s - 1];
			end
			ALU_ROL:  r = (s == 0) ? a : ((a << s) | (a >> (16 - s)));
			ALU_MOV:  r = a;
			ALU_ADD: begin
				wide = a + b;
				r = wide[15:0];
				cy = wide[16];
				ov = (a[15] == b[15]) && (r[15] != a[15]);
			end
			ALU_SUB: begin
				wide = {1'b0, a} - {1'b0, b};
				r = wide[15:0];
				cy = wide[16];   // borrow
				ov = (a[15] != b[15]) && (r[15] != a[15]);
			end
			default: r = '0;
		endcase
		if (op != ALU_NOP) begin
			z = (r == '0);
			n = r[15];
			if (op[4:3] == 2'b00) begin
				c = 1'b0;
				o = 1'b0;
			end else if (op[4:3] == 2'b01) begin
				c = cy;
			end else if (op != ALU_MOV) begin
				c = cy;
				o = ov;
			end
		end
		return r;
	endfunction

	function automatic logic cond_taken(input cond_t t, input logic z, input logic n,
			input logic c, input logic o);
		case (t)
			COND_ZERO:        return z;
			COND_NEGATIVE:    return n;
			COND_ALWAYS_LINK: return 1'b1;
			COND_CARRY:       return c;
			COND_NOT_ZERO:    return ~z;
			COND_OVERFLOW:    return o;
			default:          return 1'b0;
		endcase
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input pc_t got, input pc_t exp);
		if (got !== exp) begin
			$display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_pc(input pc_t got, input pc_t exp);
		if (got !== exp) begin
			$display("Error at %0t: pc got %h expected %h", $time, got, exp);
			errors++;
		end
	endtask

	// three instructions, the last one an OR so carry and overflow end cleared
	task automatic push_const(input int rd, input word_t v);
		prog.push_back(enc_imm(ALU_OR, rd, 0, v[15:8]));
		prog.push_back(enc_imm(ALU_SHL, rd, rd, 8'd8));
		prog.push_back(enc_imm(ALU_OR, rd, rd, v[7:0]));
	endtask

	task automatic push_halt();
		prog.push_back(enc_branch(COND_ALWAYS_LINK, prog.size()));
	endtask

	task automatic load_program();
		@(posedge CLK);
		rst <= 1'b1;
		foreach (prog[i]) begin
			@(posedge CLK);
			prog_we   <= 1'b1;
			prog_addr <= i[7:0];
			prog_data <= prog[i];
		end
		@(posedge CLK);
		prog_we <= 1'b0;
		repeat (5) @(posedge CLK);
		rst <= 1'b0;
	endtask

	task automatic wait_store(input int idx, output pc_t addr, output word_t data);
		int k;
		k = 0;
		@(negedge CLK);
		while (!dm_we && k < STORE_TIMEOUT) begin
			@(negedge CLK);
			k++;
		end
		if (!dm_we) begin
			$display("timeout, no store seen in case %0d", idx);
			$display("Test FAILED");
			$finish;
		end else begin
			addr = dm_addr;
			data = dm_wdata;
		end
	endtask

	task automatic run_case(input int idx);
		test_entry_t e;
		word_t       a, b, bx, res;
		logic        z, n, c, o, taken;
		int          p, err0;
		pc_t         got_a;
		word_t       got_d;
		e = cases[idx];
		err0 = errors;
		rng = xorshift(rng);
		a = e.fixed ? e.a : rng[15:0];
		b = e.fixed ? e.b : rng[31:16];
		z = 1'b0;   // flags left by the OR that loads 0x00aa
		n = 1'b0;
		c = 1'b0;
		o = 1'b0;
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
		push_const(1, a);
		push_const(2, b);
		push_const(4, 16'h0010);
		push_const(5, 16'h0055);   // not-taken marker
		push_const(6, 16'h00aa);   // taken marker
		case (e.kind)
			K_REG, K_IMM: begin
				if (e.kind == K_REG) begin
					prog.push_back(enc_reg(e.op, 3, 1, 2));
					bx = b;
				end else begin
					prog.push_back(enc_imm(e.op, 3, 1, b[7:0]));
					bx = (e.op[4:3] == 2'b00) ? {8'h00, b[7:0]} : {{8{b[7]}}, b[7:0]};
				end
				res = ref_alu(e.op, a, bx, z, n, c, o);
				prog.push_back(enc_store(4, 3));
				exp_addr.push_back(8'h10);
				exp_data.push_back(res);
				push_halt();
				exp_pc = prog.size();
			end
			K_MEM: begin
				prog.push_back(enc_store(4, 1));
				prog.push_back(enc_load(7, 4));
				push_const(8, 16'h0011);
				prog.push_back(enc_store(8, 7));
				exp_addr.push_back(8'h10);
				exp_data.push_back(a);
				exp_addr.push_back(8'h11);
				exp_data.push_back(a);
				push_halt();
				exp_pc = prog.size();
			end
			K_BR, K_NOP, K_MOV: begin
				prog.push_back(enc_reg(e.op, 3, 1, 2));
				res = ref_alu(e.op, a, b, z, n, c, o);
				if (e.kind == K_NOP)
					prog.push_back(enc_reg(ALU_NOP, 7, 1, 2));
				if (e.kind == K_MOV) begin
					prog.push_back(enc_reg(ALU_MOV, 7, 2, 0));
					res = ref_alu(ALU_MOV, b, 16'h0000, z, n, c, o);
				end
				taken = cond_taken(e.cond, z, n, c, o);
				p = prog.size();
				prog.push_back(enc_branch(e.cond, p + 3));
				prog.push_back(enc_store(4, 5));
				push_halt();
				prog.push_back(enc_store(4, 6));
				push_halt();
				exp_addr.push_back(8'h10);
				exp_data.push_back(taken ? 16'h00aa : 16'h0055);
				exp_pc = taken ? p + 5 : p + 3;
			end
			default: begin
				p = prog.size() + 3;   // jump sits after the target load
				push_const(8, p + 3);
				prog.push_back(enc_jump(9, 8));
				prog.push_back(enc_store(4, 5));   // skipped
				push_halt();
				prog.push_back(enc_store(4, 9));
				push_halt();
				exp_addr.push_back(8'h10);
				exp_data.push_back(p + 1);   // link is pc plus one
				exp_pc = p + 5;
			end
		endcase
		load_program();
		foreach (exp_data[i]) begin
			wait_store(idx, got_a, got_d);
			check_addr("dm_addr", got_a, exp_addr[i]);
			check_word("dm_wdata", got_d, exp_data[i]);
		end
		repeat (8) @(negedge CLK);   // two instructions, halt loop reached
		check_pc(pc, exp_pc);
		if (errors == err0) begin
			cases_ok++;
			$display("case %0d kind %0d op %b cond %b: ok", idx, e.kind, e.op, e.cond);
		end else begin
			$display("case %0d kind %0d op %b cond %b: mismatch", idx, e.kind, e.op, e.cond);
		end
	endtask

	initial begin
		rst = 1'b1;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		rng = 32'hf978;
		errors = 0;
		cases_ok = 0;
		cases[0]  = '{K_REG, ALU_AND,  COND_NONE, 1'b0, 16'h0, 16'h0};
		cases[1]  = '{K_REG, ALU_OR,   COND_NONE, 1'b0, 16'h0, 16'h0};
		cases[2]  = '{K_REG, ALU_XOR,  COND_NONE, 1'b0, 16'h0, 16'h0};
		cases[3]  = '{K_REG, ALU_NOT,  COND_NONE, 1'b0, 16'h0, 16'h0};
		cases[4]  = '{K_REG, ALU_NAND, COND_NONE, 1'b0, 16'h0, 16'h0};
		cases[5]  = '{K_REG, ALU_SHL,  COND_NONE, 1'b0, 16'h0, 16'h0};
		cases[6]  = '{K_REG, ALU_SHR,  COND_NONE, 1'b0, 16'h0, 16'h0};
		cases[7]  = '{K_REG, ALU_SAR,  COND_NONE, 1'b1, 16'h8421, 16'h0005};
		cases[8]  = '{K_REG, ALU_ROL,  COND_NONE, 1'b0, 16'h0, 16'h0};
		cases[9]  = '{K_REG, ALU_ADD,  COND_NONE, 1'b0, 16'h0, 16'h0};
		cases[10] = '{K_REG, ALU_SUB,  COND_NONE, 1'b0, 16'h0, 16'h0};
		cases[11] = '{K_IMM, ALU_ADD,  COND_NONE, 1'b1, 16'h1000, 16'h00f0};
		cases[12] = '{K_IMM, ALU_SUB,  COND_NONE, 1'b0, 16'h0, 16'h0};
		cases[13] = '{K_IMM, ALU_XOR,  COND_NONE, 1'b1, 16'hffff, 16'h0081};
		cases[14] = '{K_IMM, ALU_SHR,  COND_NONE, 1'b0, 16'h0, 16'h0};
		cases[15] = '{K_MEM, ALU_NOP,  COND_NONE, 1'b0, 16'h0, 16'h0};
		cases[16] = '{K_BR,  ALU_ADD,  COND_CARRY, 1'b1, 16'hfff0, 16'h0020};
		cases[17] = '{K_BR,  ALU_ADD,  COND_OVERFLOW, 1'b1, 16'h7000, 16'h7000};
		cases[18] = '{K_BR,  ALU_SUB,  COND_ZERO, 1'b1, 16'h1234, 16'h1234};
		cases[19] = '{K_BR,  ALU_AND,  COND_NEGATIVE, 1'b0, 16'h0, 16'h0};
		cases[20] = '{K_BR,  ALU_ADD,  COND_NEVER, 1'b1, 16'hffff, 16'h0001};
		cases[21] = '{K_NOP, ALU_ADD,  COND_ZERO, 1'b1, 16'h1234, 16'h0001};
		cases[22] = '{K_MOV, ALU_ADD,  COND_OVERFLOW, 1'b1, 16'h7fff, 16'h0001};
		cases[23] = '{K_JMP, ALU_NOP,  COND_NONE, 1'b0, 16'h0, 16'h0};
		repeat (5) @(posedge CLK);
		for (int i = 0; i < NUM_CASES; i++)
			run_case(i);
		assert_fails = i_dut.u_ctrl.i_asserts.fails;
		$display("%0d of %0d cases ok, %0d errors, %0d assertion failures",
			cases_ok, NUM_CASES, errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* files.f */
src/cpu_pkg.sv
src/unit_control.sv
src/fetch_unit.sv
src/reg_bank.sv
src/alu.sv
src/flag_unit.sv
src/data_mem.sv
src/cpu_top.sv
dv/cpu_asserts.sv
dv/tb_cpu.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - src/cpu_pkg.sv
  - src/unit_control.sv
  - src/fetch_unit.sv
  - src/reg_bank.sv
  - src/alu.sv
  - src/flag_unit.sv
  - src/data_mem.sv
  - src/cpu_top.sv
  - target: test
    files:
      - dv/cpu_asserts.sv
      - dv/tb_cpu.sv
